//--- hw/bus_pkg.sv
package bus_pkg;

  // ------------------------------
  // bus widths and decode fields
  // ------------------------------
  localparam int ADDR_W     = 32;              // byte address
  localparam int DATA_W     = 32;              // register word
  localparam int N_REGIONS  = 8;               // regions selected by addr[22:20]
  localparam int REGION_LSB = 20;              // lowest region bit
  localparam int REGION_W   = 3;               // region field width
  localparam int N_SLAVES   = 3;               // regions 0..2 have a slave

  localparam int REG_HK  = 0;                  // housekeeping
  localparam int REG_PID = 1;                  // proportional controller
  localparam int REG_DAC = 2;                  // offset levels and DAC

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [REGION_LSB-1:0] ofs_t;        // offset inside a region

  // ------------------------------
  // register offsets
  // ------------------------------
  localparam ofs_t OFS_HK_ID  = 'h00;          // read only
  localparam ofs_t OFS_HK_LED = 'h04;

  localparam ofs_t OFS_SP_A = 'h00;            // channel a setpoint
  localparam ofs_t OFS_KP_A = 'h04;            // channel a gain
  localparam ofs_t OFS_EN_A = 'h08;            // channel a enable
  localparam ofs_t OFS_SP_B = 'h10;
  localparam ofs_t OFS_KP_B = 'h14;
  localparam ofs_t OFS_EN_B = 'h18;

  localparam ofs_t OFS_LVL_A = 'h00;           // offset level a
  localparam ofs_t OFS_LVL_B = 'h04;           // offset level b

  localparam data_t HK_ID = 32'h0001_0001;     // board identification word

endpackage

//--- hw/sig_pkg.sv
package sig_pkg;

  // ------------------------------
  // sample formats
  // ------------------------------
  localparam int N_CH   = 2;                   // two analog channels
  localparam int SMP_W  = 14;                  // converter resolution
  localparam int GAIN_W = 12;                  // proportional gain width
  localparam int PROD_W = SMP_W + 1 + GAIN_W;  // error has one extra bit

  typedef logic signed [SMP_W-1:0]  sample_t;  // two's complement sample
  typedef logic        [SMP_W-1:0]  code_t;    // raw negative-slope code
  typedef logic signed [GAIN_W-1:0] gain_t;

  // ------------------------------
  // limits and conversion
  // ------------------------------
  localparam sample_t SMP_MAX = 14'h1FFF;      // +8191
  localparam sample_t SMP_MIN = 14'h2000;      // -8192

  // sample = CODE_MID - code, code = CODE_MID - sample
  localparam code_t CODE_MID = 14'd8191;

  // product is scaled down by this many bits
  localparam int KP_SHIFT = 8;

endpackage

//--- hw/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
  input  logic                                adc_clk,
  input  logic                                rst_n_i,
  input  bus_pkg::addr_t                      sys_addr_i,   // held until ack
  input  logic                                sys_wen_i,    // write pulse from master
  input  logic                                sys_ren_i,    // read pulse from master
  output logic [bus_pkg::N_REGIONS-1:0]       sys_wen_o,    // per-region write strobe
  output logic [bus_pkg::N_REGIONS-1:0]       sys_ren_o,    // per-region read strobe
  input  bus_pkg::data_t                      slv_rdata_i [bus_pkg::N_SLAVES],
  input  logic [bus_pkg::N_SLAVES-1:0]        slv_ack_i,
  input  logic [bus_pkg::N_SLAVES-1:0]        slv_err_i,
  output bus_pkg::data_t                      sys_rdata_o,
  output logic                                sys_ack_o,
  output logic                                sys_err_o
);

  logic [bus_pkg::REGION_W-1:0]  region;   // addr[22:20]
  logic [bus_pkg::N_REGIONS-1:0] sel;      // one-hot region select
  logic                          mapped;   // region has a slave
  logic                          unm_q;    // reply for empty regions

  // ------------------------------
  // region select and strobes
  // ------------------------------
  assign region    = sys_addr_i[bus_pkg::REGION_LSB +: bus_pkg::REGION_W];
  assign sel       = bus_pkg::N_REGIONS'(1) << region;
  assign mapped    = |sel[bus_pkg::N_SLAVES-1:0];
  assign sys_wen_o = sel & {bus_pkg::N_REGIONS{sys_wen_i}};   // only addressed slave sees it
  assign sys_ren_o = sel & {bus_pkg::N_REGIONS{sys_ren_i}};

  // empty region answers by itself one cycle later
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      unm_q <= 1'b0;
    end else begin
      unm_q <= (sys_wen_i | sys_ren_i) & ~mapped;
    end
  end

  // ------------------------------
  // reply mux
  // ------------------------------
  always_comb begin
    sys_rdata_o = '0;                      // zero data on unmapped reply
    sys_ack_o   = unm_q;
    sys_err_o   = unm_q;                   // unmapped region is always an error
    for (int i = 0; i < bus_pkg::N_SLAVES; i++) begin
      if (sel[i]) begin
        sys_rdata_o = slv_rdata_i[i];
        sys_ack_o   = slv_ack_i[i];
        sys_err_o   = slv_err_i[i];
      end
    end
  end

  // master never issues read and write together
  a_no_rw: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !(sys_wen_i && sys_ren_i));

endmodule

//--- hw/hk_regs.sv
`timescale 1ns/1ps

module hk_regs (
  input  logic           adc_clk,
  input  logic           rst_n_i,
  input  bus_pkg::addr_t sys_addr_i,
  input  bus_pkg::data_t sys_wdata_i,
  input  logic           sys_wen_i,
  input  logic           sys_ren_i,
  output bus_pkg::data_t sys_rdata_o,
  output logic           sys_ack_o,
  output logic           sys_err_o,
  output logic [7:0]     led_o
);

  bus_pkg::ofs_t  ofs;       // offset inside the region
  bus_pkg::data_t rd_d;      // read word before register
  logic           hit;       // offset is known
  logic [7:0]     led_q;

  assign ofs   = sys_addr_i[bus_pkg::REGION_LSB-1:0];
  assign led_o = led_q;

  // read decode
  always_comb begin
    rd_d = '0;
    hit  = 1'b1;
    case (ofs)
      bus_pkg::OFS_HK_ID:  rd_d = bus_pkg::HK_ID;
      bus_pkg::OFS_HK_LED: rd_d = {24'h0, led_q};   // led in low byte
      default:             hit  = 1'b0;
    endcase
  end

  // ------------------------------
  // registers and reply
  // ------------------------------
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      led_q     <= '0;
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end else begin
      if (sys_wen_i && ofs == bus_pkg::OFS_HK_LED) begin
        led_q <= sys_wdata_i[7:0];                   // id write falls through silently
      end
      sys_ack_o <= sys_wen_i | sys_ren_i;            // one cycle after strobe
      sys_err_o <= (sys_wen_i | sys_ren_i) & ~hit;
    end
  end

  always_ff @(posedge adc_clk) begin
    sys_rdata_o <= rd_d;                             // sampled with the strobe
  end

  // one request in flight, so ack stays a single pulse
  a_ack_pulse: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_ack_o |=> !sys_ack_o);

endmodule

//--- hw/adc_frontend.sv
`timescale 1ns/1ps

module adc_frontend (
  input  logic            adc_clk,
  input  logic            rst_n_i,
  input  sig_pkg::code_t  adc_dat_a_i,   // negative-slope code, ch a
  input  sig_pkg::code_t  adc_dat_b_i,   // negative-slope code, ch b
  output sig_pkg::sample_t adc_a_o,      // two's complement
  output sig_pkg::sample_t adc_b_o
);

  sig_pkg::sample_t a_q;
  sig_pkg::sample_t b_q;

  // ------------------------------
  // code to sample, 1 cycle
  // ------------------------------
  // code 0 maps to +8191, full scale to -8192
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= $signed(sig_pkg::CODE_MID - adc_dat_a_i);   // wraps mod 2^14
      b_q <= $signed(sig_pkg::CODE_MID - adc_dat_b_i);
    end
  end

  assign adc_a_o = a_q;
  assign adc_b_o = b_q;

endmodule

//--- hw/p_controller.sv
`timescale 1ns/1ps

module p_controller (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  bus_pkg::addr_t   sys_addr_i,
  input  bus_pkg::data_t   sys_wdata_i,
  input  logic             sys_wen_i,
  input  logic             sys_ren_i,
  output bus_pkg::data_t   sys_rdata_o,
  output logic             sys_ack_o,
  output logic             sys_err_o,
  input  sig_pkg::sample_t adc_a_i,
  input  sig_pkg::sample_t adc_b_i,
  output sig_pkg::sample_t pid_a_o,   // feedback term a
  output sig_pkg::sample_t pid_b_o    // feedback term b
);

  bus_pkg::ofs_t                  ofs;
  bus_pkg::data_t                 rd_d;
  logic                           hit;
  sig_pkg::sample_t               sp_q [sig_pkg::N_CH];   // setpoints
  sig_pkg::gain_t                 kp_q [sig_pkg::N_CH];   // gains
  logic [sig_pkg::N_CH-1:0]       en_q;                   // channel enables

  assign ofs = sys_addr_i[bus_pkg::REGION_LSB-1:0];

  // ------------------------------
  // register file
  // ------------------------------
  always_comb begin
    rd_d = '0;
    hit  = 1'b1;
    case (ofs)
      bus_pkg::OFS_SP_A: rd_d = bus_pkg::data_t'(sp_q[0]);   // sign extended
      bus_pkg::OFS_KP_A: rd_d = bus_pkg::data_t'(kp_q[0]);
      bus_pkg::OFS_EN_A: rd_d = {31'h0, en_q[0]};
      bus_pkg::OFS_SP_B: rd_d = bus_pkg::data_t'(sp_q[1]);
      bus_pkg::OFS_KP_B: rd_d = bus_pkg::data_t'(kp_q[1]);
      bus_pkg::OFS_EN_B: rd_d = {31'h0, en_q[1]};
      default:           hit  = 1'b0;                        // unknown offset
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      sp_q      <= '{default: '0};
      kp_q      <= '{default: '0};
      en_q      <= '0;
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end else begin
      if (sys_wen_i) begin
        case (ofs)
          bus_pkg::OFS_SP_A: sp_q[0] <= sys_wdata_i[sig_pkg::SMP_W-1:0];
          bus_pkg::OFS_KP_A: kp_q[0] <= sys_wdata_i[sig_pkg::GAIN_W-1:0];
          bus_pkg::OFS_EN_A: en_q[0] <= sys_wdata_i[0];
          bus_pkg::OFS_SP_B: sp_q[1] <= sys_wdata_i[sig_pkg::SMP_W-1:0];
          bus_pkg::OFS_KP_B: kp_q[1] <= sys_wdata_i[sig_pkg::GAIN_W-1:0];
          bus_pkg::OFS_EN_B: en_q[1] <= sys_wdata_i[0];
          default: ;                                         // nothing changes
        endcase
      end
      sys_ack_o <= sys_wen_i | sys_ren_i;
      sys_err_o <= (sys_wen_i | sys_ren_i) & ~hit;
    end
  end

  always_ff @(posedge adc_clk) begin
    sys_rdata_o <= rd_d;
  end

  // ------------------------------
  // proportional pipeline, 2 cycles
  // ------------------------------
  for (genvar ch = 0; ch < sig_pkg::N_CH; ch++) begin : g_ch
    sig_pkg::sample_t                    smp;
    logic signed [sig_pkg::SMP_W:0]      err_d;     // setpoint minus sample, 15 bit
    logic signed [sig_pkg::PROD_W-1:0]   prod_d;
    logic signed [sig_pkg::PROD_W-1:0]   prod_q;    // stage 1
    logic signed [sig_pkg::PROD_W-1:0]   shift_d;
    sig_pkg::sample_t                    pid_q;     // stage 2

    assign smp     = (ch == 0) ? adc_a_i : adc_b_i;
    assign err_d   = sp_q[ch] - smp;
    assign prod_d  = err_d * kp_q[ch];                 // full precision product
    assign shift_d = prod_q >>> sig_pkg::KP_SHIFT;     // keeps sign

    always_ff @(posedge adc_clk) begin
      if (!rst_n_i) begin
        prod_q <= '0;
        pid_q  <= '0;
      end else begin
        prod_q <= prod_d;
        if (!en_q[ch]) begin
          pid_q <= '0;                                 // disabled channel is silent
        end else if (shift_d > sig_pkg::SMP_MAX) begin
          pid_q <= sig_pkg::SMP_MAX;
        end else if (shift_d < sig_pkg::SMP_MIN) begin
          pid_q <= sig_pkg::SMP_MIN;
        end else begin
          pid_q <= shift_d[sig_pkg::SMP_W-1:0];
        end
      end
    end
  end

  assign pid_a_o = g_ch[0].pid_q;
  assign pid_b_o = g_ch[1].pid_q;

  // master waits for the ack before its next strobe
  a_one_req: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (sys_wen_i || sys_ren_i) |=> !(sys_wen_i || sys_ren_i));

endmodule

//--- hw/dac_output.sv
`timescale 1ns/1ps

module dac_output (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  bus_pkg::addr_t   sys_addr_i,
  input  bus_pkg::data_t   sys_wdata_i,
  input  logic             sys_wen_i,
  input  logic             sys_ren_i,
  output bus_pkg::data_t   sys_rdata_o,
  output logic             sys_ack_o,
  output logic             sys_err_o,
  input  sig_pkg::sample_t pid_a_i,
  input  sig_pkg::sample_t pid_b_i,
  output sig_pkg::code_t   dac_dat_a_o,   // negative-slope DAC code
  output sig_pkg::code_t   dac_dat_b_o
);

  bus_pkg::ofs_t    ofs;
  bus_pkg::data_t   rd_d;
  logic             hit;
  sig_pkg::sample_t lvl_q [sig_pkg::N_CH];   // constant offset per channel

  assign ofs = sys_addr_i[bus_pkg::REGION_LSB-1:0];

  // ------------------------------
  // level registers
  // ------------------------------
  always_comb begin
    rd_d = '0;
    hit  = 1'b1;
    case (ofs)
      bus_pkg::OFS_LVL_A: rd_d = bus_pkg::data_t'(lvl_q[0]);
      bus_pkg::OFS_LVL_B: rd_d = bus_pkg::data_t'(lvl_q[1]);
      default:            hit  = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      lvl_q     <= '{default: '0};
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end else begin
      if (sys_wen_i && ofs == bus_pkg::OFS_LVL_A) begin
        lvl_q[0] <= sys_wdata_i[sig_pkg::SMP_W-1:0];
      end
      if (sys_wen_i && ofs == bus_pkg::OFS_LVL_B) begin
        lvl_q[1] <= sys_wdata_i[sig_pkg::SMP_W-1:0];
      end
      sys_ack_o <= sys_wen_i | sys_ren_i;
      sys_err_o <= (sys_wen_i | sys_ren_i) & ~hit;
    end
  end

  always_ff @(posedge adc_clk) begin
    sys_rdata_o <= rd_d;
  end

  // ------------------------------
  // sum, saturate, code, 1 cycle
  // ------------------------------
  for (genvar ch = 0; ch < sig_pkg::N_CH; ch++) begin : g_ch
    sig_pkg::sample_t               pid;
    logic signed [sig_pkg::SMP_W:0] sum_d;    // one guard bit
    sig_pkg::sample_t               sat_d;
    sig_pkg::code_t                 code_q;

    assign pid   = (ch == 0) ? pid_a_i : pid_b_i;
    assign sum_d = pid + lvl_q[ch];

    always_comb begin
      case (sum_d[sig_pkg::SMP_W -: 2])
        2'b01:   sat_d = sig_pkg::SMP_MAX;              // pos overflow
        2'b10:   sat_d = sig_pkg::SMP_MIN;              // neg overflow
        default: sat_d = sum_d[sig_pkg::SMP_W-1:0];
      endcase
    end

    always_ff @(posedge adc_clk) begin
      if (!rst_n_i) begin
        code_q <= sig_pkg::CODE_MID;                    // zero sample
      end else begin
        code_q <= sig_pkg::CODE_MID - $unsigned(sat_d); // back to neg slope
      end
    end
  end

  assign dac_dat_a_o = g_ch[0].code_q;
  assign dac_dat_b_o = g_ch[1].code_q;

endmodule

//--- hw/pitaya_top.sv
`timescale 1ns/1ps

module pitaya_top (
  input  logic           adc_clk,
  input  logic           rst_n_i,
  input  sig_pkg::code_t adc_dat_a_i,   // ADC ch a
  input  sig_pkg::code_t adc_dat_b_i,   // ADC ch b
  output sig_pkg::code_t dac_dat_a_o,   // DAC ch a
  output sig_pkg::code_t dac_dat_b_o,   // DAC ch b
  output logic [7:0]     led_o,
  input  bus_pkg::addr_t sys_addr_i,
  input  bus_pkg::data_t sys_wdata_i,
  input  logic           sys_wen_i,
  input  logic           sys_ren_i,
  output bus_pkg::data_t sys_rdata_o,
  output logic           sys_ack_o,
  output logic           sys_err_o
);

  logic [bus_pkg::N_REGIONS-1:0] sys_wen;            // per-region strobes
  logic [bus_pkg::N_REGIONS-1:0] sys_ren;
  bus_pkg::data_t                slv_rdata [bus_pkg::N_SLAVES];
  logic [bus_pkg::N_SLAVES-1:0]  slv_ack;
  logic [bus_pkg::N_SLAVES-1:0]  slv_err;
  sig_pkg::sample_t              adc_a;            // converted samples
  sig_pkg::sample_t              adc_b;
  sig_pkg::sample_t              pid_a;            // feedback terms
  sig_pkg::sample_t              pid_b;

  // ------------------------------
  // bus decode
  // ------------------------------
  bus_decoder u_dec (
    .adc_clk, .rst_n_i, .sys_addr_i, .sys_wen_i, .sys_ren_i,
    .sys_wen_o   (sys_wen),
    .sys_ren_o   (sys_ren),
    .slv_rdata_i (slv_rdata),
    .slv_ack_i   (slv_ack),
    .slv_err_i   (slv_err),
    .sys_rdata_o, .sys_ack_o, .sys_err_o
  );

  hk_regs u_hk (
    .adc_clk, .rst_n_i, .sys_addr_i, .sys_wdata_i,
    .sys_wen_i   (sys_wen[bus_pkg::REG_HK]),
    .sys_ren_i   (sys_ren[bus_pkg::REG_HK]),
    .sys_rdata_o (slv_rdata[bus_pkg::REG_HK]),
    .sys_ack_o   (slv_ack[bus_pkg::REG_HK]),
    .sys_err_o   (slv_err[bus_pkg::REG_HK]),
    .led_o
  );

  // ------------------------------
  // sample path, 4 cycles
  // ------------------------------
  adc_frontend u_adc (
    .adc_clk, .rst_n_i, .adc_dat_a_i, .adc_dat_b_i,
    .adc_a_o (adc_a),
    .adc_b_o (adc_b)
  );

  p_controller u_pid (
    .adc_clk, .rst_n_i, .sys_addr_i, .sys_wdata_i,
    .sys_wen_i   (sys_wen[bus_pkg::REG_PID]),
    .sys_ren_i   (sys_ren[bus_pkg::REG_PID]),
    .sys_rdata_o (slv_rdata[bus_pkg::REG_PID]),
    .sys_ack_o   (slv_ack[bus_pkg::REG_PID]),
    .sys_err_o   (slv_err[bus_pkg::REG_PID]),
    .adc_a_i     (adc_a),
    .adc_b_i     (adc_b),
    .pid_a_o     (pid_a),
    .pid_b_o     (pid_b)
  );

  dac_output u_dac (
    .adc_clk, .rst_n_i, .sys_addr_i, .sys_wdata_i,
    .sys_wen_i   (sys_wen[bus_pkg::REG_DAC]),
    .sys_ren_i   (sys_ren[bus_pkg::REG_DAC]),
    .sys_rdata_o (slv_rdata[bus_pkg::REG_DAC]),
    .sys_ack_o   (slv_ack[bus_pkg::REG_DAC]),
    .sys_err_o   (slv_err[bus_pkg::REG_DAC]),
    .pid_a_i     (pid_a),
    .pid_b_i     (pid_b),
    .dac_dat_a_o, .dac_dat_b_o
  );

endmodule

//--- bench/tb_tests.svh
// ------------------------------
// directed tests
// ------------------------------

task automatic test_housekeeping();
  bus_pkg::data_t rd;
  bit             err;
  logic [7:0]     led;
  led = 8'(next_rand());
  @(negedge adc_clk);
  check_code("reset_dac_a", sig_pkg::CODE_MID, dac_dat_a_o);   // zero sample after reset
  check_code("reset_dac_b", sig_pkg::CODE_MID, dac_dat_b_o);
  check_data("reset_led", '0, {24'h0, led_o});
  bus_read(reg_addr(bus_pkg::REG_HK, bus_pkg::OFS_HK_ID), rd, err);
  check_flag("hk_id_err", 1'b0, err);
  check_data("hk_id", bus_pkg::HK_ID, rd);
  write_checked("hk_led_wr", reg_addr(bus_pkg::REG_HK, bus_pkg::OFS_HK_LED), {24'h0, led});
  check_data("hk_led_pin", {24'h0, led}, {24'h0, led_o});
  bus_read(reg_addr(bus_pkg::REG_HK, bus_pkg::OFS_HK_LED), rd, err);
  check_flag("hk_led_rd_err", 1'b0, err);
  check_data("hk_led_rd", {24'h0, led}, rd);
  write_checked("hk_id_wr", reg_addr(bus_pkg::REG_HK, bus_pkg::OFS_HK_ID), ~bus_pkg::HK_ID);
  bus_read(reg_addr(bus_pkg::REG_HK, bus_pkg::OFS_HK_ID), rd, err);
  check_data("hk_id_kept", bus_pkg::HK_ID, rd);                // id is read only
endtask

task automatic test_bus_errors();
  bus_pkg::data_t rd;
  bit             err;
  bus_read(reg_addr(5, '0), rd, err);                          // empty region
  check_flag("unmapped_err", 1'b1, err);
  check_data("unmapped_data", '0, rd);
  bus_write(reg_addr(7, 'h10), 32'hdead_beef, err);
  check_flag("unmapped_wr_err", 1'b1, err);
  bus_read(reg_addr(bus_pkg::REG_HK, 'h0c), rd, err);          // no such offset
  check_flag("hk_bad_ofs_err", 1'b1, err);
endtask

task automatic test_offset_path();
  logic [31:0] r;
  int          lvl_a;
  int          lvl_b;
  write_checked("off_en_a", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_EN_A), '0);
  write_checked("off_en_b", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_EN_B), '0);
  for (int i = 0; i < 3; i++) begin
    r     = next_rand();
    lvl_a = $signed(r[13:0]);                                  // full sample range
    lvl_b = $signed(r[29:16]);
    write_checked("off_lvl_a", reg_addr(bus_pkg::REG_DAC, bus_pkg::OFS_LVL_A),
                  bus_pkg::data_t'(lvl_a));
    write_checked("off_lvl_b", reg_addr(bus_pkg::REG_DAC, bus_pkg::OFS_LVL_B),
                  bus_pkg::data_t'(lvl_b));
    settle(4);
    check_code("offset_a", sample_to_code(lvl_a), dac_dat_a_o);
    check_code("offset_b", sample_to_code(lvl_b), dac_dat_b_o);
  end
endtask

task automatic test_feedback();
  logic [31:0]    r;
  sig_pkg::code_t code_a;
  sig_pkg::code_t code_b;
  int             sp_a;
  int             sp_b;
  int             kp_a;
  int             kp_b;
  int             lvl_a;
  int             lvl_b;
  bit             en_b;
  for (int i = 0; i < 4; i++) begin
    r      = next_rand();
    code_a = r[13:0];
    code_b = r[29:16];
    r      = next_rand();
    sp_a   = $signed(r[13:0]);
    sp_b   = $signed(r[29:16]);
    r      = next_rand();
    kp_a   = $signed(r[7:0]);                                  // small gain, mostly linear
    kp_b   = $signed(r[27:16]);                                // full gain, often clipped
    r      = next_rand();
    lvl_a  = $signed(r[11:0]);
    lvl_b  = $signed(r[27:16]);
    en_b   = (i != 2);                                         // one pass with ch b off
    drive_adc(code_a, code_b);                                 // held through the writes
    write_checked("fb_sp_a", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_SP_A),
                  bus_pkg::data_t'(sp_a));
    write_checked("fb_kp_a", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_KP_A),
                  bus_pkg::data_t'(kp_a));
    write_checked("fb_en_a", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_EN_A), 32'h1);
    write_checked("fb_sp_b", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_SP_B),
                  bus_pkg::data_t'(sp_b));
    write_checked("fb_kp_b", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_KP_B),
                  bus_pkg::data_t'(kp_b));
    write_checked("fb_en_b", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_EN_B), {31'h0, en_b});
    write_checked("fb_lvl_a", reg_addr(bus_pkg::REG_DAC, bus_pkg::OFS_LVL_A),
                  bus_pkg::data_t'(lvl_a));
    write_checked("fb_lvl_b", reg_addr(bus_pkg::REG_DAC, bus_pkg::OFS_LVL_B),
                  bus_pkg::data_t'(lvl_b));
    settle(4);
    check_code("feedback_a", expected_dac(sp_a, kp_a, code_a, 1'b1, lvl_a), dac_dat_a_o);
    check_code("feedback_b", expected_dac(sp_b, kp_b, code_b, en_b, lvl_b), dac_dat_b_o);
  end
endtask

// feedback of 8000 plus a level of 8000 lands far beyond either limit
task automatic set_channels(input int kp_a, input int lvl_a, input int kp_b, input int lvl_b);
  write_checked("sat_sp_a", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_SP_A), 32'd4000);
  write_checked("sat_kp_a", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_KP_A),
                bus_pkg::data_t'(kp_a));
  write_checked("sat_en_a", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_EN_A), 32'h1);
  write_checked("sat_sp_b", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_SP_B), 32'd4000);
  write_checked("sat_kp_b", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_KP_B),
                bus_pkg::data_t'(kp_b));
  write_checked("sat_en_b", reg_addr(bus_pkg::REG_PID, bus_pkg::OFS_EN_B), 32'h1);
  write_checked("sat_lvl_a", reg_addr(bus_pkg::REG_DAC, bus_pkg::OFS_LVL_A),
                bus_pkg::data_t'(lvl_a));
  write_checked("sat_lvl_b", reg_addr(bus_pkg::REG_DAC, bus_pkg::OFS_LVL_B),
                bus_pkg::data_t'(lvl_b));
  settle(4);
endtask

task automatic test_saturation();
  drive_adc(sig_pkg::CODE_MID, sig_pkg::CODE_MID);             // both samples zero
  set_channels(512, 8000, -512, -8000);
  check_code("sat_max_a", sample_to_code(int'(sig_pkg::SMP_MAX)), dac_dat_a_o);
  check_code("sat_min_b", sample_to_code(int'(sig_pkg::SMP_MIN)), dac_dat_b_o);
  set_channels(-512, -8000, 512, 8000);                        // mirrored
  check_code("sat_min_a", sample_to_code(int'(sig_pkg::SMP_MIN)), dac_dat_a_o);
  check_code("sat_max_b", sample_to_code(int'(sig_pkg::SMP_MAX)), dac_dat_b_o);
endtask

//--- bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int N_TESTS   = 5;
  localparam int TEST_LEN  = 200;   // cycles allowed per test
  localparam int ACK_LIMIT = 16;    // cycles to wait for one ack

  logic           adc_clk = 1'b0;
  logic           rst_n_i;
  sig_pkg::code_t adc_dat_a_i;
  sig_pkg::code_t adc_dat_b_i;
  sig_pkg::code_t dac_dat_a_o;
  sig_pkg::code_t dac_dat_b_o;
  logic [7:0]     led_o;
  bus_pkg::addr_t sys_addr_i;
  bus_pkg::data_t sys_wdata_i;
  logic           sys_wen_i;
  logic           sys_ren_i;
  bus_pkg::data_t sys_rdata_o;
  logic           sys_ack_o;
  logic           sys_err_o;

  logic [31:0]    rng_state = 32'h5af9;   // xorshift state

  pitaya_top u_dut (.*);

  always #20 adc_clk = ~adc_clk;          // 40 ns period

  // ------------------------------
  // run control and checks
  // ------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input bus_pkg::data_t exp,
                            input bus_pkg::data_t act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_code(input string name, input sig_pkg::code_t exp,
                            input sig_pkg::code_t act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input bit act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic bus_pkg::addr_t reg_addr(input int region, input bus_pkg::ofs_t ofs);
    return (bus_pkg::addr_t'(region) << bus_pkg::REGION_LSB) | bus_pkg::addr_t'(ofs);
  endfunction

  // ack sampled on the falling edge, away from register updates
  task automatic wait_ack(output bus_pkg::data_t rdata, output bit err);
    int n;
    n = 0;
    @(negedge adc_clk);
    while (sys_ack_o !== 1'b1 && n < ACK_LIMIT) begin
      n++;
      @(negedge adc_clk);
    end
    if (sys_ack_o !== 1'b1) begin
      abort_run("bus request got no ack from the DUT");
    end else begin
      rdata = sys_rdata_o;
      err   = sys_err_o;
    end
  endtask

  task automatic bus_write(input bus_pkg::addr_t addr, input bus_pkg::data_t data,
                           output bit err);
    bus_pkg::data_t unused;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= data;
    sys_wen_i   <= 1'b1;   // one-cycle strobe
    @(posedge adc_clk);
    sys_wen_i   <= 1'b0;
    wait_ack(unused, err);
  endtask

  task automatic bus_read(input bus_pkg::addr_t addr, output bus_pkg::data_t data,
                          output bit err);
    @(posedge adc_clk);
    sys_addr_i <= addr;
    sys_ren_i  <= 1'b1;
    @(posedge adc_clk);
    sys_ren_i  <= 1'b0;
    wait_ack(data, err);
  endtask

  task automatic write_checked(input string name, input bus_pkg::addr_t addr,
                               input bus_pkg::data_t data);
    bit err;
    bus_write(addr, data, err);
    check_flag(name, 1'b0, err);   // known offset never errors
  endtask

  task automatic drive_adc(input sig_pkg::code_t code_a, input sig_pkg::code_t code_b);
    @(posedge adc_clk);
    adc_dat_a_i <= code_a;
    adc_dat_b_i <= code_b;
  endtask

  // n rising edges, then park on a falling edge
  task automatic settle(input int n);
    repeat (n) @(posedge adc_clk);
    @(negedge adc_clk);
  endtask

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic int code_to_sample(input sig_pkg::code_t code);
    return int'(sig_pkg::CODE_MID) - int'(code);   // negative slope
  endfunction

  function automatic int clamp_sample(input int v);
    if (v > int'(sig_pkg::SMP_MAX)) return int'(sig_pkg::SMP_MAX);
    if (v < int'(sig_pkg::SMP_MIN)) return int'(sig_pkg::SMP_MIN);
    return v;
  endfunction

  function automatic int p_term(input int sp, input int kp, input int smp, input bit en);
    if (!en) return 0;
    return clamp_sample(((sp - smp) * kp) >>> sig_pkg::KP_SHIFT);   // floor shift
  endfunction

  function automatic sig_pkg::code_t sample_to_code(input int smp);
    return sig_pkg::code_t'(int'(sig_pkg::CODE_MID) - smp);
  endfunction

  function automatic sig_pkg::code_t expected_dac(input int sp, input int kp,
                                                  input sig_pkg::code_t code,
                                                  input bit en, input int lvl);
    return sample_to_code(clamp_sample(p_term(sp, kp, code_to_sample(code), en) + lvl));
  endfunction

  `include "tb_tests.svh"

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    rst_n_i     = 1'b0;
    adc_dat_a_i = sig_pkg::CODE_MID;   // zero sample
    adc_dat_b_i = sig_pkg::CODE_MID;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    repeat (3) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    test_housekeeping();
    test_bus_errors();
    test_offset_path();
    test_feedback();
    test_saturation();
    @(negedge adc_clk);
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin : watchdog
    repeat (N_TESTS * TEST_LEN) @(posedge adc_clk);
    abort_run("timeout, the tests did not finish in the allowed time");
  end

endmodule

//--- tb.f
+incdir+bench
hw/bus_pkg.sv
hw/sig_pkg.sv
hw/bus_decoder.sv
hw/hk_regs.sv
hw/adc_frontend.sv
hw/p_controller.sv
hw/dac_output.sv
hw/pitaya_top.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
# compile the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
